// ==== hdl/zx_audio_pkg.sv ====
`default_nettype none

package zx_audio_pkg;

  //////////////////////////////////////////////////////////////////////
  // CPU side
  //////////////////////////////////////////////////////////////////////

  // Z80 I/O bus, as presented to the audio block
  typedef struct packed {
    logic [15:0] addr;   // Full address, port in low byte
    logic        iorq_n;
    logic        rd_n;
    logic        wr_n;
    logic [7:0]  data;   // Data written by the CPU
  } cpu_bus_t;

  // ULA port bit positions
  localparam int ULA_MIC_BIT = 3;  // Write, mic output
  localparam int ULA_SPK_BIT = 4;  // Write, speaker
  localparam int ULA_EAR_BIT = 6;  // Read, ear input

  // Specdrum style 8-bit DAC port, low address byte
  localparam logic [7:0] PORT_DAC = 8'hdf;

  //////////////////////////////////////////////////////////////////////
  // Audio side
  //////////////////////////////////////////////////////////////////////

  // One snapshot of every sound source
  typedef struct packed {
    logic       ear;
    logic       mic;
    logic       spk;
    logic [7:0] dac;
  } sample_t;

  // Mixed level, max 255 + 128 + 64 + 32 = 479
  localparam int LEVEL_W = 9;

endpackage

`default_nettype wire

// ==== hdl/io_port_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module io_port_decoder (
  input  logic                   clk,
  input  logic                   rst_n,
  input  zx_audio_pkg::cpu_bus_t bus,
  input  logic                   ear,
  input  logic                   prod_ack,
  output logic [7:0]             cpu_dout,
  output logic                   wait_n,
  output logic                   prod_req,
  output zx_audio_pkg::sample_t  prod_data
);
  import zx_audio_pkg::*;

  logic       ear_meta, ear_sync;   // Two-flop synchronizer
  logic       in_cycle;             // io_active seen last clock
  logic       io_active, cyc_start;
  logic       is_ula, is_dac;
  logic       snd_wr_start;
  logic       slot_free, wr_go;
  logic       pend;                 // Write parked, CPU held
  logic       pend_ula, pend_dac, pend_ear;
  logic [7:0] pend_data;
  logic       use_ula, use_dac, use_ear;
  logic [7:0] use_data;
  logic       mic_q, spk_q, ear_q;  // Sound registers
  logic [7:0] dac_q;

  //////////////////////////////////////////////////////////////////////
  // Ear input synchronizer
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      ear_meta <= 1'b0;
      ear_sync <= 1'b0;
    end else begin
      ear_meta <= ear;
      ear_sync <= ear_meta;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Cycle detect and port decode
  //////////////////////////////////////////////////////////////////////
  assign io_active = !bus.iorq_n && (!bus.rd_n || !bus.wr_n);
  assign cyc_start = io_active && !in_cycle;  // First clock of the cycle only

  assign is_ula = !bus.addr[0];                // Any even port
  assign is_dac = bus.addr[7:0] == PORT_DAC;
  assign snd_wr_start = cyc_start && !bus.wr_n && (is_ula || is_dac);

  always_ff @(posedge clk) begin
    if (!rst_n) in_cycle <= 1'b0;
    else        in_cycle <= io_active;
  end

  // Output slot free once req and ack are both back low
  assign slot_free = !prod_req && !prod_ack;
  assign wr_go     = slot_free && (snd_wr_start || pend);

  // Live bus on the start clock, parked copy while stalled
  assign use_ula  = pend ? pend_ula  : is_ula;
  assign use_dac  = pend ? pend_dac  : is_dac;
  assign use_ear  = pend ? pend_ear  : ear_sync;
  assign use_data = pend ? pend_data : bus.data;

  always_ff @(posedge clk) begin
    if (snd_wr_start) begin
      pend_ula  <= is_ula;
      pend_dac  <= is_dac;
      pend_ear  <= ear_sync;  // Ear as seen at cycle start
      pend_data <= bus.data;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Sound registers and producer side of the link
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      mic_q    <= 1'b0;
      spk_q    <= 1'b0;
      dac_q    <= 8'h00;
      ear_q    <= 1'b0;
      pend     <= 1'b0;
      prod_req <= 1'b0;
    end else begin
      if (wr_go) begin
        pend  <= 1'b0;
        ear_q <= use_ear;
        if (use_ula) begin
          mic_q <= use_data[ULA_MIC_BIT];
          spk_q <= use_data[ULA_SPK_BIT];
        end
        if (use_dac) dac_q <= use_data;
        prod_req <= 1'b1;             // Snapshot is stable from here
      end else if (snd_wr_start) begin
        pend <= 1'b1;                 // Slot busy, stall the CPU
      end
      if (prod_req && prod_ack) prod_req <= 1'b0;
    end
  end

  // Registers only move on wr_go, so data holds while req is up
  assign prod_data.ear = ear_q;
  assign prod_data.mic = mic_q;
  assign prod_data.spk = spk_q;
  assign prod_data.dac = dac_q;

  assign wait_n = !pend;  // Low from one clock after start until captured

  // Read data, held until the next cycle starts
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      cpu_dout <= 8'hff;
    end else if (cyc_start && !bus.rd_n) begin
      cpu_dout <= 8'hff;                                // Open bus
      if (is_ula) cpu_dout[ULA_EAR_BIT] <= ear_sync;
    end
  end

endmodule

`default_nettype wire

// ==== hdl/sample_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

module sample_fifo #(
  parameter int FIFO_DEPTH = 8  // Power of two
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  prod_req,
  input  zx_audio_pkg::sample_t prod_data,
  output logic                  prod_ack,
  output logic                  cons_req,
  output zx_audio_pkg::sample_t cons_data,
  input  logic                  cons_ack
);
  import zx_audio_pkg::*;

  localparam int PTR_W = $clog2(FIFO_DEPTH);

  sample_t        mem [FIFO_DEPTH];
  logic [PTR_W:0] wr_ptr, rd_ptr;  // MSB is the wrap bit
  logic           full, empty;
  logic           push, pop;

  // Same slot, different lap means full
  assign full  = (wr_ptr[PTR_W] != rd_ptr[PTR_W]) &&
                 (wr_ptr[PTR_W-1:0] == rd_ptr[PTR_W-1:0]);
  assign empty = wr_ptr == rd_ptr;

  //////////////////////////////////////////////////////////////////////
  // Input side, four-phase receiver
  //////////////////////////////////////////////////////////////////////

  // Take the word on a fresh req, ack is held off while full
  assign push = prod_req && !prod_ack && !full;

  always_ff @(posedge clk) begin
    if (push) mem[wr_ptr[PTR_W-1:0]] <= prod_data;
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ptr   <= '0;
      prod_ack <= 1'b0;
    end else begin
      if (push) begin
        wr_ptr   <= wr_ptr + 1'b1;
        prod_ack <= 1'b1;
      end else if (!prod_req && prod_ack) begin
        prod_ack <= 1'b0;  // Phase 4
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Output side, four-phase sender
  //////////////////////////////////////////////////////////////////////

  // Entry leaves on the first clock the mixer acks
  assign pop = cons_req && cons_ack;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rd_ptr   <= '0;
      cons_req <= 1'b0;
    end else begin
      if (pop) begin
        rd_ptr   <= rd_ptr + 1'b1;
        cons_req <= 1'b0;
      end else if (!cons_req && !cons_ack && !empty) begin
        cons_req <= 1'b1;  // Head entry already in place
      end
    end
  end

  // Head slot is never written while it holds data, so stable under req
  assign cons_data = mem[rd_ptr[PTR_W-1:0]];

endmodule

`default_nettype wire

// ==== hdl/audio_mixer_dac.sv ====
`timescale 1ns/1ps
`default_nettype none

module audio_mixer_dac #(
  parameter int SAMPLE_DIV = 16  // Clocks per sample, at least 4
) (
  input  logic                             clk,
  input  logic                             rst_n,
  input  logic                             cons_req,
  input  zx_audio_pkg::sample_t            cons_data,
  output logic                             cons_ack,
  output logic [zx_audio_pkg::LEVEL_W-1:0] audio_level,
  output logic                             dac_load,
  output logic                             audio_out
);
  import zx_audio_pkg::*;

  localparam int DIV_W = $clog2(SAMPLE_DIV);

  logic [DIV_W-1:0]   div_cnt;
  logic               tick, take;
  logic               upd;          // Sample latched, level due next clock
  sample_t            smp;
  logic [LEVEL_W-1:0] mix;
  logic [LEVEL_W-1:0] sd_acc;
  logic [LEVEL_W:0]   sd_sum;       // Extra bit is the carry

  //////////////////////////////////////////////////////////////////////
  // Sample tick
  //////////////////////////////////////////////////////////////////////
  assign tick = div_cnt == DIV_W'(SAMPLE_DIV - 1);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      div_cnt <= '0;
    end else if (tick) begin
      div_cnt <= '0;
    end else begin
      div_cnt <= div_cnt + 1'b1;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Consumer side of the link
  //////////////////////////////////////////////////////////////////////
  assign take = tick && cons_req && !cons_ack;  // One sample per tick at most

  always_ff @(posedge clk) begin
    if (take) smp <= cons_data;
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      cons_ack <= 1'b0;
      upd      <= 1'b0;
    end else begin
      upd <= take;
      if (take)                       cons_ack <= 1'b1;
      else if (cons_ack && !cons_req) cons_ack <= 1'b0;  // Phase 4
    end
  end

  // Mixing rule, dac plus fixed weights for the 1-bit sources
  assign mix = LEVEL_W'(smp.dac)
             + (smp.spk ? LEVEL_W'(128) : LEVEL_W'(0))
             + (smp.ear ? LEVEL_W'(64)  : LEVEL_W'(0))
             + (smp.mic ? LEVEL_W'(32)  : LEVEL_W'(0));

  // Parallel DAC port, level and strobe change together
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      audio_level <= '0;
      dac_load    <= 1'b0;
    end else begin
      dac_load <= upd;              // Single clock pulse
      if (upd) audio_level <= mix;  // Holds between samples
    end
  end

  //////////////////////////////////////////////////////////////////////
  // First-order sigma-delta
  //////////////////////////////////////////////////////////////////////

  // Carry count over 512 clocks equals the level
  assign sd_sum = {1'b0, sd_acc} + {1'b0, audio_level};

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      sd_acc    <= '0;
      audio_out <= 1'b0;
    end else begin
      sd_acc    <= sd_sum[LEVEL_W-1:0];
      audio_out <= sd_sum[LEVEL_W];
    end
  end

endmodule

`default_nettype wire

// ==== hdl/zx_audio_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module zx_audio_top #(
  parameter int FIFO_DEPTH = 8,   // Snapshots in flight
  parameter int SAMPLE_DIV = 16   // Clocks per mixer sample
) (
  input  logic                             clk,
  input  logic                             rst_n,
  input  zx_audio_pkg::cpu_bus_t           bus,
  input  logic                             ear,
  output logic [7:0]                       cpu_dout,
  output logic                             wait_n,
  output logic [zx_audio_pkg::LEVEL_W-1:0] audio_level,
  output logic                             dac_load,
  output logic                             audio_out
);
  import zx_audio_pkg::*;

  // Decoder to FIFO
  logic    prod_req, prod_ack;
  sample_t prod_data;

  // FIFO to mixer
  logic    cons_req, cons_ack;
  sample_t cons_data;

  //////////////////////////////////////////////////////////////////////
  // Port decode, FIFO, mixer
  //////////////////////////////////////////////////////////////////////
  io_port_decoder decoder_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .bus       (bus),
    .ear       (ear),
    .prod_ack  (prod_ack),
    .cpu_dout  (cpu_dout),
    .wait_n    (wait_n),     // Back-pressure from a full FIFO
    .prod_req  (prod_req),
    .prod_data (prod_data)
  );

  sample_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) fifo_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .prod_req  (prod_req),
    .prod_data (prod_data),
    .prod_ack  (prod_ack),
    .cons_req  (cons_req),
    .cons_data (cons_data),
    .cons_ack  (cons_ack)
  );

  audio_mixer_dac #(.SAMPLE_DIV(SAMPLE_DIV)) mixer_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .cons_req    (cons_req),
    .cons_data   (cons_data),
    .cons_ack    (cons_ack),
    .audio_level (audio_level),
    .dac_load    (dac_load),
    .audio_out   (audio_out)
  );

endmodule

`default_nettype wire

// ==== testbench/zx_audio_sva.sv ====
`timescale 1ns/1ps
`default_nettype none

module zx_audio_sva #(
  parameter int FIFO_DEPTH = 8
) (
  input logic                  clk,
  input logic                  rst_n,
  input logic                  prod_req,
  input logic                  prod_ack,
  input zx_audio_pkg::sample_t prod_data,
  input logic                  cons_req,
  input logic                  cons_ack,
  input zx_audio_pkg::sample_t cons_data
);

  int   fill;   // Entries held, counted from the handshakes alone
  logic ack_q;  // prod_ack one clock back

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      fill  <= 0;
      ack_q <= 1'b0;
    end else begin
      ack_q <= prod_ack;
      fill  <= fill + int'(prod_ack && !ack_q) - int'(cons_req && cons_ack);
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Decoder to FIFO link
  //////////////////////////////////////////////////////////////////////
  prod_req_hold: assert property (@(posedge clk) disable iff (!rst_n)
    prod_req && !prod_ack |=> prod_req)
    else $error("prod_req fell before prod_ack");

  prod_data_stable: assert property (@(posedge clk) disable iff (!rst_n)
    prod_req |=> !prod_req || $stable(prod_data))
    else $error("prod_data moved while prod_req was high");

  prod_ack_needs_req: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(prod_ack) |-> prod_req)
    else $error("prod_ack rose without prod_req");

  // No ack while every slot already holds a word
  prod_ack_not_full: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(prod_ack) |-> $past(fill) < FIFO_DEPTH)
    else $error("prod_ack rose while the FIFO was full");

  //////////////////////////////////////////////////////////////////////
  // FIFO to mixer link
  //////////////////////////////////////////////////////////////////////
  cons_req_hold: assert property (@(posedge clk) disable iff (!rst_n)
    cons_req && !cons_ack |=> cons_req)
    else $error("cons_req fell before cons_ack");

  cons_data_stable: assert property (@(posedge clk) disable iff (!rst_n)
    cons_req |=> !cons_req || $stable(cons_data))
    else $error("cons_data moved while cons_req was high");

  cons_ack_needs_req: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(cons_ack) |-> cons_req)
    else $error("cons_ack rose without cons_req");

endmodule

bind sample_fifo zx_audio_sva #(.FIFO_DEPTH(FIFO_DEPTH)) sva_i (
  .clk       (clk),
  .rst_n     (rst_n),
  .prod_req  (prod_req),
  .prod_ack  (prod_ack),
  .prod_data (prod_data),
  .cons_req  (cons_req),
  .cons_ack  (cons_ack),
  .cons_data (cons_data)
);

`default_nettype wire

// ==== testbench/zx_audio_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module zx_audio_tb;
  import zx_audio_pkg::*;

  localparam int CLK_PERIOD  = 40;
  localparam int FIFO_DEPTH  = 8;
  localparam int SAMPLE_DIV  = 16;
  localparam int N_ULA       = 40;  // ULA only writes
  localparam int N_MIX       = 40;  // DAC, ULA and other odd ports
  localparam int N_BURST     = 24;
  localparam int NUM_WRITES  = N_ULA + N_MIX + N_BURST + 2;
  localparam int CYCLE_LIMIT = NUM_WRITES * (SAMPLE_DIV + 8) + 4000;

  logic               clk, rst_n, ear;
  cpu_bus_t           bus;
  logic [7:0]         cpu_dout;
  logic               wait_n, dac_load, audio_out;
  logic [LEVEL_W-1:0] audio_level;

  logic               m_mic, m_spk;  // Reference model registers
  logic [7:0]         m_dac;
  logic [LEVEL_W-1:0] exp_q[$];      // Levels still owed a dac_load
  logic [LEVEL_W-1:0] last_level;
  logic               saw_stall;
  int                 errors, checks, cycle_cnt;

  zx_audio_top #(.FIFO_DEPTH(FIFO_DEPTH), .SAMPLE_DIV(SAMPLE_DIV)) dut_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .bus         (bus),
    .ear         (ear),
    .cpu_dout    (cpu_dout),
    .wait_n      (wait_n),
    .audio_level (audio_level),
    .dac_load    (dac_load),
    .audio_out   (audio_out)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  always @(posedge clk) cycle_cnt <= cycle_cnt + 1;

  // spk 128, ear 64 and mic 32 on top of the dac byte
  function automatic logic [LEVEL_W-1:0] mix_level(input logic spk, input logic e,
                                                   input logic mic, input logic [7:0] dac);
    int lvl;
    lvl = int'(dac) + (spk ? 128 : 0) + (e ? 64 : 0) + (mic ? 32 : 0);
    return LEVEL_W'(lvl);
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Bus cycles entered and left on a falling edge
  //////////////////////////////////////////////////////////////////////
  task automatic idle(input int n);
    repeat (n) @(negedge clk);
  endtask

  task automatic io_cycle(input logic [15:0] addr, input logic rd, input logic [7:0] wdata,
                          output logic [7:0] rdata);
    bus.addr   = addr;
    bus.data   = wdata;
    bus.iorq_n = 1'b0;
    bus.rd_n   = !rd;
    bus.wr_n   = rd;
    repeat (2) @(negedge clk);       // Two clocks minimum
    while (!wait_n) @(negedge clk);  // Wait states
    rdata      = cpu_dout;
    bus.iorq_n = 1'b1;
    bus.rd_n   = 1'b1;
    bus.wr_n   = 1'b1;
    @(negedge clk);                  // One idle clock between cycles
  endtask

  task automatic cpu_write(input logic [15:0] addr, input logic [7:0] data);
    logic [7:0] rd_dummy;
    logic       snd;
    io_cycle(addr, 1'b0, data, rd_dummy);
    snd = !addr[0] || addr[7:0] == PORT_DAC;
    if (!addr[0]) begin
      m_mic = data[ULA_MIC_BIT];
      m_spk = data[ULA_SPK_BIT];
    end else if (addr[7:0] == PORT_DAC) begin
      m_dac = data;
    end
    if (snd) begin
      last_level = mix_level(m_spk, ear, m_mic, m_dac);
      exp_q.push_back(last_level);
    end
  endtask

  task automatic set_ear(input logic v);
    ear = v;
    idle(4);  // Through the synchronizer before the next cycle
  endtask

  task automatic drain();
    while (exp_q.size() != 0) @(negedge clk);
    idle(3 * SAMPLE_DIV);  // Room for a stray extra load to show up
  endtask

  //////////////////////////////////////////////////////////////////////
  // Output monitor
  //////////////////////////////////////////////////////////////////////
  always @(negedge clk) begin : load_monitor
    logic [LEVEL_W-1:0] exp_lvl;
    if (rst_n) begin
      if (!wait_n) saw_stall = 1'b1;
      if (dac_load) begin
        checks++;
        assert (exp_q.size() != 0) else begin
          errors++;
          $display("** Error at %0t: dac_load with no write pending, level %0d",
                   $time, audio_level);
        end
        if (exp_q.size() != 0) begin
          exp_lvl = exp_q.pop_front();
          assert (audio_level == exp_lvl) else begin
            errors++;
            $display("** Error at %0t: audio_level %0d, expected %0d",
                     $time, audio_level, exp_lvl);
          end
        end
      end
    end
  end

  initial begin : watchdog
    wait (cycle_cnt >= CYCLE_LIMIT);
    $display("Timeout: run still busy after %0d clocks, %0d samples never came out",
             CYCLE_LIMIT, exp_q.size());
    $display("Checks: %0d, errors: %0d", checks, errors);
    $display("Done: errors found");
    $finish;
  end

  //////////////////////////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////////////////////////
  initial begin : stimulus
    logic [15:0] addr;
    logic [7:0]  rdata, exp_rd;
    int          ones;
    void'($urandom(32'hca4d_8f6c));
    clk        = 1'b0;
    rst_n      = 1'b0;
    ear        = 1'b0;
    bus        = '{addr: 16'h0000, iorq_n: 1'b1, rd_n: 1'b1, wr_n: 1'b1, data: 8'h00};
    m_mic      = 1'b0;
    m_spk      = 1'b0;
    m_dac      = 8'h00;
    last_level = '0;
    saw_stall  = 1'b0;
    errors     = 0;
    checks     = 0;
    idle(2);
    rst_n = 1'b1;

    // Quiet after reset
    repeat (64) begin
      @(negedge clk);
      checks++;
      assert (wait_n && !dac_load && audio_level == '0 && !audio_out) else begin
        errors++;
        $display("** Error at %0t: after reset wait_n=%b dac_load=%b level=%0d out=%b",
                 $time, wait_n, dac_load, audio_level, audio_out);
      end
    end

    for (int i = 0; i < N_ULA; i++) begin
      if (i % 5 == 0) set_ear(1'($urandom_range(0, 1)));
      cpu_write(16'($urandom) & 16'hfffe, 8'($urandom));
      idle(int'($urandom_range(0, 3)));
    end

    // DAC port mixed in while odd non-DAC ports stay silent
    for (int i = 0; i < N_MIX; i++) begin
      addr = 16'($urandom);
      case ($urandom_range(0, 2))
        0: addr[7:0] = PORT_DAC;
        1: addr[0] = 1'b0;
        default: begin
          addr[0] = 1'b1;
          if (addr[7:0] == PORT_DAC) addr[7:0] = 8'hfd;
        end
      endcase
      cpu_write(addr, 8'($urandom));
      idle(int'($urandom_range(0, 3)));
    end
    drain();

    // Back-to-back burst faster than the mixer drains
    saw_stall = 1'b0;
    for (int i = 0; i < N_BURST; i++) begin
      addr = 16'($urandom);
      if (i % 2 == 0) begin
        addr[0] = 1'b0;
      end else begin
        addr[7:0] = PORT_DAC;
      end
      cpu_write(addr, 8'($urandom));
    end
    checks++;
    assert (saw_stall) else begin
      errors++;
      $display("** Error at %0t: wait_n never went low during the burst", $time);
    end
    drain();

    for (int i = 0; i < 16; i++) begin
      set_ear(1'($urandom_range(0, 1)));
      addr    = 16'($urandom);
      addr[0] = i[0];                      // Even and odd in turn
      if (i == 15) addr[7:0] = PORT_DAC;
      io_cycle(addr, 1'b1, 8'h00, rdata);
      exp_rd = addr[0] ? 8'hff : {1'b1, ear, 6'h3f};
      checks++;
      assert (rdata == exp_rd) else begin
        errors++;
        $display("** Error at %0t: read of port %h gave %h, expected %h",
                 $time, addr, rdata, exp_rd);
      end
    end

    // Final level then sigma-delta ones over one full accumulator lap
    cpu_write(16'h00fe, 8'($urandom));
    cpu_write({8'($urandom), PORT_DAC}, 8'($urandom));
    drain();
    idle(16);
    ones = 0;
    repeat (512) begin
      @(negedge clk);
      ones += int'(audio_out);
    end
    checks++;
    assert (ones == int'(last_level)) else begin
      errors++;
      $display("** Error at %0t: audio_out high %0d times in 512 clocks, expected %0d",
               $time, ones, last_level);
    end

    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== zx_audio_top.f ====
hdl/zx_audio_pkg.sv
hdl/io_port_decoder.sv
hdl/sample_fifo.sv
hdl/audio_mixer_dac.sv
hdl/zx_audio_top.sv
testbench/zx_audio_sva.sv
testbench/zx_audio_tb.sv

// ==== Makefile ====
# Verilator build and run for the audio block testbench

VERILATOR ?= verilator
TOP       ?= zx_audio_tb
FLIST     ?= zx_audio_top.f
LOG       ?= sim.log
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)

# Simulation ends in failure if the log holds the fail line or lacks the pass line
run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "Done: errors found" $(LOG); then \
		echo "Simulation FAILED, see $(LOG)"; exit 1; \
	fi
	@if ! grep -q "Done: no errors" $(LOG); then \
		echo "Simulation ended early, see $(LOG)"; exit 1; \
	fi

lint:
	$(VERILATOR) --lint-only -Wall --timing --assert --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
